// File: verilog/lsu_pkg.sv
////////////////////////////////////////////////////////////
// Load/store unit shared types
////////////////////////////////////////////////////////////

package lsu_pkg;

    // RV32 data path
    localparam int xlen     = 32;
    // Outstanding requests per direction, also the load tag FIFO depth
    localparam int max_or   = 8;
    localparam int or_cnt_w = 4;

    typedef logic [xlen-1:0]   word_t;
    typedef logic [xlen/8-1:0] strb_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [2:0]        funct3_t;

    // Width and sign codes of LOAD/STORE funct3
    localparam funct3_t f3_b  = 3'd0;
    localparam funct3_t f3_h  = 3'd1;
    localparam funct3_t f3_w  = 3'd2;
    localparam funct3_t f3_bu = 3'd4;
    localparam funct3_t f3_hu = 3'd5;

    typedef enum logic [1:0] {
        acc_none,
        acc_load,
        acc_store
    } access_e;

    // Decoded instruction handed to the unit
    typedef struct packed {
        logic      is_store;
        funct3_t   funct3;
        reg_addr_t rd;
        logic [11:0] imm12;
        word_t     rs1_val;
        word_t     rs2_val;
    } lsu_req_t;

    // What a read completion needs to write rd back
    typedef struct packed {
        reg_addr_t  rd;
        funct3_t    funct3;
        logic [1:0] offset;
    } load_tag_t;

    typedef struct packed {
        access_e   access;
        word_t     addr;
        word_t     wdata;
        strb_t     wstrb;
        load_tag_t tag;
    } lsu_op_t;

    // AXI4-lite W channel payload
    typedef struct packed {
        word_t data;
        strb_t strb;
    } axi_w_t;

    typedef struct packed {
        logic  load_misaligned;
        logic  store_misaligned;
        word_t addr;
    } lsu_exc_t;

    // Destination register write, byte-strobed
    typedef struct packed {
        reg_addr_t addr;
        word_t     val;
        strb_t     strb;
    } rd_write_t;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_serve
    } seq_state_e;

endpackage

// File: verilog/lsu_decode.sv
////////////////////////////////////////////////////////////
// Load/store request decode
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_decode (
    input  lsu_pkg::lsu_req_t req,
    input  logic              req_valid,
    input  logic              req_ready,
    output lsu_pkg::lsu_op_t  op,
    output lsu_pkg::lsu_exc_t exc
);

    import lsu_pkg::*;

    word_t      addr;
    logic [1:0] offset;
    logic       misaligned;
    logic       accept;
    strb_t      base_strb;
    word_t      wdata_rot;

    // Effective address, rs1 plus sign-extended imm12
    assign addr   = req.rs1_val + {{(xlen-12){req.imm12[11]}}, req.imm12};
    assign offset = addr[1:0];
    assign accept = req_valid && req_ready;

    // Halfwords need an even offset, words a zero offset
    always_comb begin
        case (req.funct3)
            f3_h, f3_hu: misaligned = offset[0];
            f3_w:        misaligned = (offset != 2'b00);
            default:     misaligned = 1'b0;
        endcase
    end

    // Store lanes
    always_comb begin
        case (req.funct3)
            f3_b:    base_strb = 4'b0001;
            f3_h:    base_strb = 4'b0011;
            default: base_strb = 4'b1111;
        endcase
    end

    // rs2 rotated left into the addressed byte lanes
    always_comb begin
        case (offset)
            2'd1:    wdata_rot = {req.rs2_val[23:0], req.rs2_val[31:24]};
            2'd2:    wdata_rot = {req.rs2_val[15:0], req.rs2_val[31:16]};
            2'd3:    wdata_rot = {req.rs2_val[7:0], req.rs2_val[31:8]};
            default: wdata_rot = req.rs2_val;
        endcase
    end

    always_comb begin
        if (misaligned) begin
            op.access = acc_none;
        end else if (req.is_store) begin
            op.access = acc_store;
        end else begin
            op.access = acc_load;
        end
        op.addr       = addr;
        op.wdata      = wdata_rot;
        // Loads never drive a strobe
        op.wstrb      = req.is_store ? strb_t'(base_strb << offset) : '0;
        op.tag.rd     = req.rd;
        op.tag.funct3 = req.funct3;
        op.tag.offset = offset;
    end

    // Exception only in the accept cycle of a misaligned access
    assign exc.load_misaligned  = accept && misaligned && !req.is_store;
    assign exc.store_misaligned = accept && misaligned && req.is_store;
    assign exc.addr             = (accept && misaligned) ? addr : '0;

    always_comb begin
        assert (!(exc.load_misaligned && exc.store_misaligned))
            else $error("decode flags load and store misalignment together");
    end

endmodule

// File: verilog/lsu_sequencer.sv
////////////////////////////////////////////////////////////
// Load/store AXI4-lite sequencer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_sequencer (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               req_valid,
    output logic               req_ready,
    input  lsu_pkg::lsu_op_t   op,
    output logic               awvalid,
    input  logic               awready,
    output lsu_pkg::word_t     awaddr,
    output logic               wvalid,
    input  logic               wready,
    output lsu_pkg::axi_w_t    w,
    input  logic               bvalid,
    output logic               arvalid,
    input  logic               arready,
    output lsu_pkg::word_t     araddr,
    input  logic               rvalid,
    output logic               tag_push,
    output lsu_pkg::load_tag_t tag,
    input  logic               tag_full,
    output logic               pending_read,
    output logic               pending_write
);

    import lsu_pkg::*;

    seq_state_e          state;
    logic                ready_fsm;
    logic                stall_bus;
    logic                accept;
    logic                store_acc;
    logic                load_acc;
    logic                op_store_r;
    logic [or_cnt_w-1:0] wr_cnt;
    logic [or_cnt_w-1:0] rd_cnt;
    logic                wr_full;
    logic                waiting_wr;
    logic                waiting_rd;

    assign accept    = req_valid && req_ready;
    assign store_acc = accept && (op.access == acc_store);
    assign load_acc  = accept && (op.access == acc_load);

    // Idle with a valid still unacknowledged on any channel
    assign stall_bus = (state == st_idle) &&
                       ((arvalid && !arready) || (awvalid && !awready) || (wvalid && !wready));

    assign req_ready = ready_fsm && !stall_bus && !tag_full && !wr_full;

    // Load tags go out in the accept cycle
    assign tag_push = load_acc;
    assign tag      = op.tag;

    ////////////////////////////////////////////////////////////
    // Ordering FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= st_idle;
            ready_fsm <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            arvalid   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (stall_bus) begin
                        // Drop what was taken, keep the rest up
                        if (awready) awvalid <= 1'b0;
                        if (wready) wvalid <= 1'b0;
                        if (arready) arvalid <= 1'b0;
                        state     <= st_serve;
                        ready_fsm <= 1'b0;
                    end else if (store_acc) begin
                        arvalid <= 1'b0;
                        if (waiting_rd) begin
                            // Reads still in flight
                            awvalid   <= 1'b0;
                            wvalid    <= 1'b0;
                            state     <= st_wait;
                            ready_fsm <= 1'b0;
                        end else begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                        end
                    end else if (load_acc) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b0;
                        if (waiting_wr) begin
                            arvalid   <= 1'b0;
                            state     <= st_wait;
                            ready_fsm <= 1'b0;
                        end else begin
                            arvalid <= 1'b1;
                        end
                    end else begin
                        // Nothing to issue, misaligned requests end here too
                        awvalid   <= 1'b0;
                        wvalid    <= 1'b0;
                        arvalid   <= 1'b0;
                        ready_fsm <= 1'b1;
                    end
                end

                // Opposite direction drains before issue
                st_wait: begin
                    if (op_store_r && !waiting_rd) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= st_serve;
                    end else if (!op_store_r && !waiting_wr) begin
                        arvalid <= 1'b1;
                        state   <= st_serve;
                    end
                end

                st_serve: begin
                    if (op_store_r) begin
                        if (awready) awvalid <= 1'b0;
                        if (wready) wvalid <= 1'b0;
                        // Both address and data taken, now or earlier
                        if ((!awvalid || awready) && (!wvalid || wready)) begin
                            state     <= st_idle;
                            ready_fsm <= 1'b1;
                        end
                    end else if (arready) begin
                        arvalid   <= 1'b0;
                        state     <= st_idle;
                        ready_fsm <= 1'b1;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

    // Request payload, loaded on accept only
    always_ff @(posedge aclk) begin
        if (accept) begin
            awaddr     <= op.addr;
            araddr     <= op.addr;
            w.data     <= op.wdata;
            w.strb     <= op.wstrb;
            op_store_r <= (op.access == acc_store);
        end
    end

    ////////////////////////////////////////////////////////////
    // Outstanding counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_cnt <= '0;
            rd_cnt <= '0;
        end else begin
            case ({store_acc, bvalid})
                2'b10:   wr_cnt <= wr_cnt + 1'b1;
                2'b01:   wr_cnt <= wr_cnt - 1'b1;
                default: wr_cnt <= wr_cnt;
            endcase
            case ({load_acc, rvalid})
                2'b10:   rd_cnt <= rd_cnt + 1'b1;
                2'b01:   rd_cnt <= rd_cnt - 1'b1;
                default: rd_cnt <= rd_cnt;
            endcase
        end
    end

    assign wr_full = (wr_cnt == or_cnt_w'(max_or));

    // Last completion arriving now already counts as drained
    assign waiting_wr = (wr_cnt != '0) && !((wr_cnt == or_cnt_w'(1)) && bvalid);
    assign waiting_rd = (rd_cnt != '0) && !((rd_cnt == or_cnt_w'(1)) && rvalid);

    assign pending_write = waiting_wr;
    assign pending_read  = waiting_rd;

    ////////////////////////////////////////////////////////////
    // Bus protocol checks
    ////////////////////////////////////////////////////////////

    a_aw_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (awvalid && !awready) |=> $stable(awaddr));

    a_w_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (wvalid && !wready) |=> $stable(w));

    // Single ID, one direction at a time
    a_one_dir: assert property (@(posedge aclk) disable iff (!aresetn)
        !(arvalid && awvalid));

endmodule

// File: verilog/lsu_load_return.sv
////////////////////////////////////////////////////////////
// Load completion return
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_load_return (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                tag_push,
    input  lsu_pkg::load_tag_t  tag,
    output logic                tag_full,
    input  logic                rvalid,
    input  lsu_pkg::word_t      rdata,
    output logic                rd_wr,
    output lsu_pkg::rd_write_t  rd
);

    import lsu_pkg::*;

    load_tag_t           fifo_mem [max_or];
    logic [or_cnt_w-2:0] wr_ptr;
    logic [or_cnt_w-2:0] rd_ptr;
    logic [or_cnt_w-1:0] count;
    logic                fifo_empty;
    load_tag_t           head;
    word_t               rot;

    ////////////////////////////////////////////////////////////
    // Tag FIFO, oldest outstanding load at the head
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (tag_push) begin
            fifo_mem[wr_ptr] <= tag;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (tag_push) wr_ptr <= wr_ptr + 1'b1;
            if (rvalid) rd_ptr <= rd_ptr + 1'b1;
            case ({tag_push, rvalid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign tag_full   = (count == or_cnt_w'(max_or));
    assign fifo_empty = (count == '0);
    assign head       = fifo_mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // rdata formatting
    ////////////////////////////////////////////////////////////

    // Bring the addressed byte down to lane 0
    always_comb begin
        case (head.offset)
            2'd1:    rot = {rdata[7:0], rdata[31:8]};
            2'd2:    rot = {rdata[15:0], rdata[31:16]};
            2'd3:    rot = {rdata[23:0], rdata[31:24]};
            default: rot = rdata;
        endcase
    end

    always_comb begin
        rd.addr = head.rd;
        case (head.funct3)
            f3_b:    rd.val = {{24{rot[7]}}, rot[7:0]};
            f3_bu:   rd.val = {24'd0, rot[7:0]};
            f3_h:    rd.val = {{16{rot[15]}}, rot[15:0]};
            f3_hu:   rd.val = {16'd0, rot[15:0]};
            default: rd.val = rot;
        endcase
        // Strobe keeps only lanes that came from this word
        case (head.funct3)
            f3_b, f3_bu: rd.strb = 4'b1111;
            f3_h, f3_hu: rd.strb = (head.offset == 2'd3) ? 4'b0001 : 4'b1111;
            default:     rd.strb = strb_t'(4'b1111 >> head.offset);
        endcase
    end

    // One register write per R beat
    assign rd_wr = rvalid;

    a_no_orphan_r: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid |-> !fifo_empty);

endmodule

// File: verilog/lsu_top.sv
////////////////////////////////////////////////////////////
// RV32 load/store unit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_top (
    input  logic               aclk,
    input  logic               aresetn,
    // Request side
    input  logic               req_valid,
    output logic               req_ready,
    input  lsu_pkg::lsu_req_t  req,
    output lsu_pkg::lsu_exc_t  exc,
    // Destination register write
    output logic               rd_wr,
    output lsu_pkg::rd_write_t rd,
    output logic               pending_read,
    output logic               pending_write,
    // AXI4-lite write
    output logic               awvalid,
    input  logic               awready,
    output lsu_pkg::word_t     awaddr,
    output logic               wvalid,
    input  logic               wready,
    output lsu_pkg::axi_w_t    w,
    input  logic               bvalid,
    input  logic [1:0]         bresp,
    // AXI4-lite read
    output logic               arvalid,
    input  logic               arready,
    output lsu_pkg::word_t     araddr,
    input  logic               rvalid,
    input  lsu_pkg::word_t     rdata,
    input  logic [1:0]         rresp
);

    import lsu_pkg::*;

    // Every B and R beat retires its request whatever the response code
    lsu_op_t   op;
    load_tag_t tag;
    logic      tag_push;
    logic      tag_full;

    lsu_decode decode0 (
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .op        (op),
        .exc       (exc)
    );

    lsu_sequencer seq0 (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .op            (op),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .w             (w),
        .bvalid        (bvalid),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .tag_push      (tag_push),
        .tag           (tag),
        .tag_full      (tag_full),
        .pending_read  (pending_read),
        .pending_write (pending_write)
    );

    lsu_load_return ret0 (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .tag_push (tag_push),
        .tag      (tag),
        .tag_full (tag_full),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .rd_wr    (rd_wr),
        .rd       (rd)
    );

endmodule

// File: tests/axi_mem_model.sv
////////////////////////////////////////////////////////////
// AXI4-lite memory slave model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_mem_model (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            awvalid,
    output logic            awready,
    input  lsu_pkg::word_t  awaddr,
    input  logic            wvalid,
    output logic            wready,
    input  lsu_pkg::axi_w_t w,
    output logic            bvalid,
    output logic [1:0]      bresp,
    input  logic            arvalid,
    output logic            arready,
    input  lsu_pkg::word_t  araddr,
    output logic            rvalid,
    output lsu_pkg::word_t  rdata,
    output logic [1:0]      rresp
);

    import lsu_pkg::*;

    word_t  mem [64];
    word_t  aw_q [$];
    axi_w_t w_q [$];
    word_t  ar_q [$];
    int     b_cnt;
    logic   hold_resp;

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = '0;
        end
    end

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // Handshakes and completions seen at the rising edge
    always @(posedge aclk or negedge aresetn) begin
        word_t  a;
        axi_w_t d;
        if (!aresetn) begin
            aw_q.delete();
            w_q.delete();
            ar_q.delete();
            b_cnt = 0;
        end else begin
            if (bvalid) b_cnt--;
            if (rvalid) void'(ar_q.pop_front());
            if (awvalid && awready) aw_q.push_back(awaddr);
            if (wvalid && wready) w_q.push_back(w);
            if (arvalid && arready) ar_q.push_back(araddr);
            // Write lands once address and data are both in
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                a = aw_q.pop_front();
                d = w_q.pop_front();
                for (int b = 0; b < 4; b++) begin
                    if (d.strb[b]) mem[a[7:2]][8*b +: 8] = d.data[8*b +: 8];
                end
                b_cnt++;
            end
        end
    end

    // Random stalls and response delays driven on the falling edge
    always @(negedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            rdata     <= '0;
            hold_resp <= 1'b0;
        end else begin
            awready <= ($urandom % 4) != 0;
            wready  <= ($urandom % 4) != 0;
            arready <= ($urandom % 4) != 0;
            // Quiet spells without responses let requests pile up
            if (($urandom % 32) == 0) hold_resp <= !hold_resp;
            bvalid  <= (b_cnt > 0) && !hold_resp && (($urandom % 3) == 0);
            if (ar_q.size() > 0 && !hold_resp && ($urandom % 3) == 0) begin
                rvalid <= 1'b1;
                rdata  <= mem[ar_q[0][7:2]];
            end else begin
                rvalid <= 1'b0;
                rdata  <= '0;
            end
        end
    end

endmodule

// File: tests/tb_lsu.sv
////////////////////////////////////////////////////////////
// Load/store unit testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lsu;

    import lsu_pkg::*;

    logic      aclk;
    logic      aresetn;
    logic      req_valid;
    logic      req_ready;
    lsu_req_t  req;
    lsu_exc_t  exc;
    logic      rd_wr;
    rd_write_t rd;
    logic      pending_read;
    logic      pending_write;
    logic      awvalid, awready, wvalid, wready, bvalid;
    logic      arvalid, arready, rvalid;
    word_t     awaddr, araddr, rdata;
    axi_w_t    w;
    logic [1:0] bresp, rresp;

    // Reference state
    word_t     ref_mem [64];
    rd_write_t load_q [$];
    rd_write_t exp_rd;
    word_t     exp_awaddr, exp_araddr, exp_wdata, w_masked;
    strb_t     exp_wstrb;
    int        aw_pend, ar_pend, wr_out, rd_out;

    // Expected decode of the request on the port
    word_t     cur_addr;
    logic [1:0] cur_off;
    logic      cur_mis;
    lsu_exc_t  exp_exc;
    logic      accept;

    lsu_top dut0 (
        .aclk (aclk), .aresetn (aresetn),
        .req_valid (req_valid), .req_ready (req_ready), .req (req), .exc (exc),
        .rd_wr (rd_wr), .rd (rd),
        .pending_read (pending_read), .pending_write (pending_write),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .w (w),
        .bvalid (bvalid), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rdata (rdata), .rresp (rresp)
    );

    axi_mem_model mem0 (
        .aclk (aclk), .aresetn (aresetn),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .w (w),
        .bvalid (bvalid), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rdata (rdata), .rresp (rresp)
    );

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Lane mask built from a byte strobe
    function automatic word_t strobe_mask(input strb_t s);
        word_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{s[b]}};
        end
        return m;
    endfunction

    // Expected register write for a load of word wd at byte offset off
    function automatic rd_write_t format_load(input reg_addr_t r, input funct3_t f3,
                                              input logic [1:0] off, input word_t wd);
        rd_write_t o;
        word_t sh;
        sh = wd >> (8 * off);
        o.addr = r;
        case (f3)
            f3_b:    o.val = word_t'($signed(sh[7:0]));
            f3_bu:   o.val = {24'd0, sh[7:0]};
            f3_h:    o.val = word_t'($signed(sh[15:0]));
            f3_hu:   o.val = {16'd0, sh[15:0]};
            default: o.val = sh;
        endcase
        if (f3 == f3_w) o.strb = 4'b1111 >> off;
        else if ((f3 == f3_h || f3 == f3_hu) && off == 2'd3) o.strb = 4'b0001;
        else o.strb = 4'b1111;
        return o;
    endfunction

    always_comb begin
        cur_addr = req.rs1_val + {{20{req.imm12[11]}}, req.imm12};
        cur_off  = cur_addr[1:0];
        cur_mis  = ((req.funct3 == f3_h || req.funct3 == f3_hu) && cur_off[0]) ||
                   (req.funct3 == f3_w && cur_off != 2'd0);
        accept   = req_valid && req_ready;
        exp_exc.load_misaligned  = accept && cur_mis && !req.is_store;
        exp_exc.store_misaligned = accept && cur_mis && req.is_store;
        exp_exc.addr             = (accept && cur_mis) ? cur_addr : '0;
        w_masked = w.data & strobe_mask(w.strb);
    end

    // Bookkeeping of expected traffic
    always @(posedge aclk or negedge aresetn) begin
        strb_t s;
        word_t rot;
        if (!aresetn) begin
            load_q.delete();
            aw_pend = 0;
            ar_pend = 0;
            wr_out  = 0;
            rd_out  = 0;
        end else begin
            if (awvalid && awready) aw_pend--;
            if (arvalid && arready) ar_pend--;
            if (bvalid) wr_out--;
            if (rd_wr) begin
                void'(load_q.pop_front());
                rd_out--;
            end
            if (accept && !cur_mis && req.is_store) begin
                s   = strb_t'((req.funct3 == f3_b ? 4'b0001 :
                               req.funct3 == f3_h ? 4'b0011 : 4'b1111) << cur_off);
                rot = word_t'({req.rs2_val, req.rs2_val} >> (32 - 8 * cur_off));
                exp_awaddr = cur_addr;
                exp_wstrb  = s;
                exp_wdata  = rot & strobe_mask(s);
                for (int b = 0; b < 4; b++) begin
                    if (s[b]) ref_mem[cur_addr[7:2]][8*b +: 8] = rot[8*b +: 8];
                end
                aw_pend++;
                wr_out++;
            end else if (accept && !cur_mis) begin
                exp_araddr = cur_addr;
                load_q.push_back(format_load(req.rd, req.funct3, cur_off,
                                             ref_mem[cur_addr[7:2]]));
                ar_pend++;
                rd_out++;
            end
            if (load_q.size() > 0) exp_rd = load_q[0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_exc: assert property (@(posedge aclk) disable iff (!aresetn) exc == exp_exc)
        else report_mismatch("exc differs from expected misalignment report");
    a_aw: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid |-> (awaddr == exp_awaddr && aw_pend > 0 && rd_out == 0))
        else report_mismatch("write address, count or ordering wrong");
    a_w: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid |-> (w.strb == exp_wstrb && w_masked == exp_wdata))
        else report_mismatch("write data lanes or strobe wrong");
    a_ar: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid |-> (araddr == exp_araddr && ar_pend > 0 && wr_out == 0))
        else report_mismatch("read address, count or ordering wrong");
    a_rd: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr |-> (rd_out > 0 && rd == exp_rd))
        else report_mismatch("destination write differs from reference load");
    a_aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)))
        else report_mismatch("write address changed while stalled");
    a_w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        (wvalid && !wready) |=> (wvalid && $stable(w)))
        else report_mismatch("write data changed while stalled");
    a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
        else report_mismatch("read address changed while stalled");
    a_limit: assert property (@(posedge aclk) disable iff (!aresetn)
        (wr_out <= max_or && rd_out <= max_or))
        else report_mismatch("outstanding count above limit");
    a_flags: assert property (@(posedge aclk) disable iff (!aresetn)
        ((wr_out != 0 || !pending_write) && (rd_out != 0 || !pending_read)))
        else report_mismatch("pending flag high with nothing outstanding");

    ////////////////////////////////////////////////////////////
    // Clock, reset and stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    initial begin
        funct3_t ld_f3 [5];
        funct3_t st_f3 [3];
        int tries;
        logic store_run;
        ld_f3 = '{f3_b, f3_h, f3_w, f3_bu, f3_hu};
        st_f3 = '{f3_b, f3_h, f3_w};
        void'($urandom(32'hac2f));
        store_run = 1'b0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = '0;
        end
        aresetn   = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        for (int n = 0; n < 300; n++) begin
            // Runs of one direction build up outstanding traffic
            if ((n % 20) == 0) store_run = ($urandom % 2) == 1;
            req.is_store = store_run;
            req.funct3   = req.is_store ? st_f3[$urandom % 3] : ld_f3[$urandom % 5];
            req.rd       = reg_addr_t'($urandom);
            // Addresses stay inside the 256 byte model memory
            req.imm12    = 12'($signed(int'($urandom % 128) - 64));
            req.rs1_val  = 32'd128 + ($urandom % 64);
            req.rs2_val  = $urandom;
            req_valid    = 1'b1;
            tries = 0;
            #1;
            while (!req_ready) begin
                tries++;
                if (tries > 2000) abort_run("timeout waiting for req_ready");
                @(negedge aclk);
                #1;
            end
            // Next request follows the accepting edge directly
            @(negedge aclk);
        end
        req_valid = 1'b0;
        tries = 0;
        while (wr_out != 0 || rd_out != 0) begin
            tries++;
            if (tries > 2000) abort_run("timeout waiting for outstanding traffic to drain");
            @(negedge aclk);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: sim.f
verilog/lsu_pkg.sv
verilog/lsu_decode.sv
verilog/lsu_sequencer.sv
verilog/lsu_load_return.sv
verilog/lsu_top.sv
tests/axi_mem_model.sv
tests/tb_lsu.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_lsu -f sim.f -o sim_lsu \
    && ./obj_dir/sim_lsu \
    || exit 1
